//--- source/eu_settings.svh
`ifndef EU_SETTINGS_SVH
`define EU_SETTINGS_SVH

// width of a register, operand and bus data word
`define EU_WORD_W 16

// width of one prefetch queue byte
`define EU_BYTE_W 8

// physical bus address, 1 MiB space
`define EU_PHYS_W 20

// AW CW DW BW SP BP IX IY
`define EU_NUM_GPR 8

// DS1 PS SS DS0
`define EU_NUM_SREG 4

// program counter value after reset
`define EU_PC_RESET 0

// segment base is the segment register shifted by this many bits
`define EU_SEG_SHIFT 4

`endif

//--- source/eu_pkg.sv
`default_nettype none

`include "eu_settings.svh"

package eu_pkg;

    typedef logic [`EU_BYTE_W-1:0] byte_t;
    typedef logic [`EU_WORD_W-1:0] word_t;
    typedef logic [`EU_PHYS_W-1:0] phys_addr_t;
    // AW CW DW BW SP BP IX IY, or AL CL DL BL AH CH DH BH for bytes
    typedef logic [$clog2(`EU_NUM_GPR)-1:0] gpr_id_t;
    // DS1 PS SS DS0
    typedef logic [$clog2(`EU_NUM_SREG)-1:0] sreg_id_t;

    typedef enum logic [2:0] {OPCODE, MODRM, DISP_LO, DISP_HI, IMM_LO, IMM_HI, ISSUE}
        decode_state_t;

    typedef enum logic {IDLE, BUS} exec_state_t;

    // source or destination of a move
    typedef enum logic [1:0] {REG, SREG, MEM, IMM} operand_kind_t;

    // one decoded move, ids are already steered by the direction bit
    typedef struct packed {
        operand_kind_t src_kind;
        operand_kind_t dst_kind;
        logic          word;
        gpr_id_t       src_id;
        gpr_id_t       dst_id;
        logic [1:0]    mod;
        logic [2:0]    rm;
        word_t         disp;
        word_t         imm;
    } mov_op_t;

    // wishbone classic, master to slave
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        phys_addr_t adr;
        word_t      dat_o;
        logic [1:0] sel;
    } wb_req_t;

    // wishbone classic, slave to master
    typedef struct packed {
        word_t dat_i;
        logic  ack;
    } wb_rsp_t;

    typedef struct packed {
        logic          valid;
        operand_kind_t kind;
        logic          word;
        gpr_id_t       id;
        word_t         data;
    } writeback_t;

endpackage

`default_nettype wire

//--- source/instruction_decoder.sv
`default_nettype none

`include "eu_settings.svh"

module instruction_decoder
    import eu_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset,
    input  wire byte_t   queue_data,
    input  wire logic    queue_empty,
    output logic         queue_pop,
    output word_t        pc,
    output mov_op_t      op,
    output logic         op_valid,
    input  wire logic    op_ready
);

    decode_state_t state;
    decode_state_t next_state;

    // instruction bytes collected so far
    byte_t opcode;
    byte_t modrm;
    word_t disp;
    word_t imm;

    // bytes under decode, the incoming byte while it is being popped
    byte_t dec_opcode;
    byte_t dec_modrm;

    logic is_mov_rm;
    logic is_sreg_mov;
    logic is_mov_imm_reg;
    logic is_mov_imm_rm;
    logic need_modrm;
    logic need_disp;
    logic disp_word;
    logic need_imm;
    logic imm_word;
    operand_kind_t rm_kind;

    assign dec_opcode = (state == OPCODE) ? queue_data : opcode;
    assign dec_modrm  = (state == MODRM) ? queue_data : modrm;

    // 88-8B, 8C/8E, B0-BF, C6/C7
    assign is_mov_rm      = (dec_opcode[7:2] == 6'b100010);
    assign is_sreg_mov    = (dec_opcode == 8'h8C) || (dec_opcode == 8'h8E);
    assign is_mov_imm_reg = (dec_opcode[7:4] == 4'hB);
    assign is_mov_imm_rm  = (dec_opcode[7:1] == 7'b1100011);

    assign need_modrm = is_mov_rm || is_sreg_mov || is_mov_imm_rm;
    assign need_imm   = is_mov_imm_reg || is_mov_imm_rm;
    // w bit sits at bit 3 for the short register form
    assign imm_word   = is_mov_imm_reg ? dec_opcode[3] : dec_opcode[0];

    // mod 00 with rm 110 is a direct 16-bit address
    assign disp_word = (dec_modrm[7:6] == 2'b10) ||
                       (dec_modrm[7:6] == 2'b00 && dec_modrm[2:0] == 3'b110);
    assign need_disp = disp_word || (dec_modrm[7:6] == 2'b01);

    always_comb
    begin
        case (state)
            OPCODE:  next_state = need_modrm ? MODRM : (need_imm ? IMM_LO : ISSUE);
            MODRM:   next_state = need_disp ? DISP_LO : (need_imm ? IMM_LO : ISSUE);
            DISP_LO: next_state = disp_word ? DISP_HI : (need_imm ? IMM_LO : ISSUE);
            DISP_HI: next_state = need_imm ? IMM_LO : ISSUE;
            IMM_LO:  next_state = imm_word ? IMM_HI : ISSUE;
            IMM_HI:  next_state = ISSUE;
            default: next_state = op_ready ? OPCODE : ISSUE;
        endcase
    end

    // one byte per cycle whenever the queue has one
    assign queue_pop = (state != ISSUE) && !queue_empty;
    assign op_valid  = (state == ISSUE);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= OPCODE;
            pc    <= word_t'(`EU_PC_RESET);
        end
        else if (queue_pop || state == ISSUE)
        begin
            state <= next_state;
            if (queue_pop)
                pc <= pc + word_t'(1);
        end
    end

    // byte capture, the high halves are cleared for byte-sized fields
    always_ff @(posedge clk)
    begin
        if (queue_pop)
        begin
            case (state)
                OPCODE:  opcode <= queue_data;
                MODRM:   modrm <= queue_data;
                DISP_LO: disp <= {8'h00, queue_data};
                DISP_HI: disp[15:8] <= queue_data;
                IMM_LO:  imm <= {8'h00, queue_data};
                IMM_HI:  imm[15:8] <= queue_data;
                default: opcode <= opcode;
            endcase
        end
    end

    assign rm_kind = (modrm[7:6] == 2'b11) ? REG : MEM;

    always_comb
    begin
        op          = '0;
        op.word     = opcode[0];
        op.mod      = modrm[7:6];
        op.rm       = modrm[2:0];
        op.disp     = disp;
        op.imm      = imm;
        // unknown opcodes leave as a move with no destination
        op.src_kind = IMM;
        op.dst_kind = IMM;
        if (is_mov_rm)
        begin
            // d bit set means the reg field is the destination
            op.src_kind = opcode[1] ? rm_kind : REG;
            op.dst_kind = opcode[1] ? REG : rm_kind;
            op.src_id   = opcode[1] ? modrm[2:0] : modrm[5:3];
            op.dst_id   = opcode[1] ? modrm[5:3] : modrm[2:0];
        end
        else if (is_sreg_mov)
        begin
            op.word     = 1'b1;
            op.src_kind = opcode[1] ? rm_kind : SREG;
            op.dst_kind = opcode[1] ? SREG : rm_kind;
            op.src_id   = opcode[1] ? modrm[2:0] : {1'b0, modrm[4:3]};
            op.dst_id   = opcode[1] ? {1'b0, modrm[4:3]} : modrm[2:0];
        end
        else if (is_mov_imm_reg)
        begin
            op.word     = opcode[3];
            op.dst_kind = REG;
            op.dst_id   = opcode[2:0];
        end
        else if (is_mov_imm_rm)
        begin
            op.dst_kind = rm_kind;
            op.dst_id   = modrm[2:0];
        end
    end

endmodule

`default_nettype wire

//--- source/mov_execute.sv
`default_nettype none

`include "eu_settings.svh"

module mov_execute
    import eu_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset,
    input  wire mov_op_t op,
    input  wire logic    op_valid,
    output logic         op_ready,
    output gpr_id_t      gpr_rd_id,
    output sreg_id_t     sreg_rd_id,
    output logic         rd_word,
    input  wire word_t   gpr_rd_data,
    input  wire word_t   sreg_rd_data,
    output gpr_id_t      base_id,
    output gpr_id_t      index_id,
    input  wire word_t   base_data,
    input  wire word_t   index_data,
    output sreg_id_t     ea_seg_id,
    input  wire word_t   ea_seg_data,
    output wb_req_t      wb_req,
    input  wire wb_rsp_t wb_rsp,
    output writeback_t   result
);

    localparam gpr_id_t  BW  = 3'd3;
    localparam gpr_id_t  BP  = 3'd5;
    localparam gpr_id_t  IX  = 3'd6;
    localparam gpr_id_t  IY  = 3'd7;
    localparam sreg_id_t SS  = 2'd2;
    localparam sreg_id_t DS0 = 2'd3;

    exec_state_t state;

    logic direct;
    logic use_base;
    logic use_index;
    word_t disp_ext;
    word_t ea;
    phys_addr_t phys_addr;
    word_t src_value;
    word_t load_data;

    // destination of an outstanding load
    operand_kind_t ld_kind;
    logic ld_word;
    gpr_id_t ld_id;

    // register read request follows the op while it waits
    assign gpr_rd_id  = op.src_id;
    assign sreg_rd_id = op.src_id[1:0];
    assign rd_word    = op.word;

    // rm 0xx is base plus index, 10x index only, 11x base only
    assign direct    = (op.mod == 2'b00) && (op.rm == 3'b110);
    assign base_id   = (op.rm[2] ? !op.rm[0] : op.rm[1]) ? BP : BW;
    assign index_id  = op.rm[0] ? IY : IX;
    assign use_base  = !op.rm[2] || (op.rm[1] && !direct);
    assign use_index = !op.rm[2] || !op.rm[1];
    // BP-based modes default to SS
    assign ea_seg_id = ((op.rm[2:1] == 2'b01) || (op.rm == 3'b110 && !direct)) ? SS : DS0;

    always_comb
    begin
        if (op.mod == 2'b01)
            disp_ext = {{8{op.disp[7]}}, op.disp[7:0]};
        else if (op.mod == 2'b10 || direct)
            disp_ext = op.disp;
        else
            disp_ext = '0;
    end

    assign ea = (use_base ? base_data : '0) + (use_index ? index_data : '0) + disp_ext;
    // wraps at 1 MiB
    assign phys_addr = (phys_addr_t'(ea_seg_data) << `EU_SEG_SHIFT) + phys_addr_t'(ea);

    assign src_value = (op.src_kind == REG) ? gpr_rd_data :
                       (op.src_kind == SREG) ? sreg_rd_data : op.imm;
    // byte loads arrive on the low lane
    assign load_data = ld_word ? wb_rsp.dat_i : {8'h00, wb_rsp.dat_i[7:0]};

    // hold off while a load result is still on its way into the register file
    assign op_ready = (state == IDLE) && !result.valid;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state        <= IDLE;
            wb_req.cyc   <= 1'b0;
            wb_req.stb   <= 1'b0;
            wb_req.we    <= 1'b0;
            result.valid <= 1'b0;
        end
        else
        begin
            result.valid <= 1'b0;
            case (state)
                IDLE:
                begin
                    if (op_valid && op_ready)
                    begin
                        ld_kind <= op.dst_kind;
                        ld_word <= op.word;
                        ld_id   <= op.dst_id;
                        if (op.src_kind == MEM || op.dst_kind == MEM)
                        begin
                            wb_req.cyc   <= 1'b1;
                            wb_req.stb   <= 1'b1;
                            wb_req.we    <= (op.dst_kind == MEM);
                            wb_req.adr   <= phys_addr;
                            wb_req.dat_o <= op.word ? src_value : {8'h00, src_value[7:0]};
                            wb_req.sel   <= op.word ? 2'b11 : 2'b01;
                            state        <= BUS;
                        end
                        else if (op.dst_kind == REG || op.dst_kind == SREG)
                        begin
                            result.valid <= 1'b1;
                            result.kind  <= op.dst_kind;
                            result.word  <= op.word;
                            result.id    <= op.dst_id;
                            result.data  <= src_value;
                        end
                    end
                end
                default:
                begin
                    // request stays put through any number of wait states
                    if (wb_rsp.ack)
                    begin
                        wb_req.cyc <= 1'b0;
                        wb_req.stb <= 1'b0;
                        state      <= IDLE;
                        if (!wb_req.we)
                        begin
                            result.valid <= 1'b1;
                            result.kind  <= ld_kind;
                            result.word  <= ld_word;
                            result.id    <= ld_id;
                            result.data  <= load_data;
                        end
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/register_writeback.sv
`default_nettype none

`include "eu_settings.svh"

module register_writeback
    import eu_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire writeback_t result,
    input  wire gpr_id_t    gpr_rd_id,
    input  wire sreg_id_t   sreg_rd_id,
    input  wire logic       rd_word,
    output word_t           gpr_rd_data,
    output word_t           sreg_rd_data,
    input  wire gpr_id_t    base_id,
    input  wire gpr_id_t    index_id,
    output word_t           base_data,
    output word_t           index_data,
    input  wire sreg_id_t   ea_seg_id,
    output word_t           ea_seg_data
);

    word_t gpr [`EU_NUM_GPR];
    word_t sreg [`EU_NUM_SREG];

    // byte ids 0-3 are low halves of AW..BW, 4-7 the high halves
    word_t rd_byte_src;
    gpr_id_t wr_id;
    word_t wr_merged;

    assign rd_byte_src = gpr[{1'b0, gpr_rd_id[1:0]}];
    assign gpr_rd_data = rd_word ? gpr[gpr_rd_id] :
                         (gpr_rd_id[2] ? {8'h00, rd_byte_src[15:8]} :
                                         {8'h00, rd_byte_src[7:0]});

    assign sreg_rd_data = sreg[sreg_rd_id];
    assign base_data    = gpr[base_id];
    assign index_data   = gpr[index_id];
    assign ea_seg_data  = sreg[ea_seg_id];

    // a byte write keeps the other half of the word
    assign wr_id     = result.word ? result.id : {1'b0, result.id[1:0]};
    assign wr_merged = result.word ? result.data :
                       (result.id[2] ? {result.data[7:0], gpr[wr_id][7:0]} :
                                       {gpr[wr_id][15:8], result.data[7:0]});

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < `EU_NUM_GPR; i++)
                gpr[i] <= '0;
            for (int i = 0; i < `EU_NUM_SREG; i++)
                sreg[i] <= '0;
        end
        else if (result.valid)
        begin
            if (result.kind == SREG)
                sreg[result.id[1:0]] <= result.data;
            else
                gpr[wr_id] <= wr_merged;
        end
    end

endmodule

`default_nettype wire

//--- source/execution_unit.sv
`default_nettype none

module execution_unit
    import eu_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset,
    input  wire byte_t   queue_data,
    input  wire logic    queue_empty,
    output logic         queue_pop,
    output word_t        pc,
    output wb_req_t      wb_req,
    input  wire wb_rsp_t wb_rsp
);

    // decode to execute handshake
    mov_op_t op;
    logic op_valid;
    logic op_ready;

    // register file read and write paths
    gpr_id_t gpr_rd_id;
    sreg_id_t sreg_rd_id;
    logic rd_word;
    word_t gpr_rd_data;
    word_t sreg_rd_data;
    gpr_id_t base_id;
    gpr_id_t index_id;
    word_t base_data;
    word_t index_data;
    sreg_id_t ea_seg_id;
    word_t ea_seg_data;
    writeback_t result;

    instruction_decoder u_decoder (
        .clk         (clk),
        .reset       (reset),
        .queue_data  (queue_data),
        .queue_empty (queue_empty),
        .queue_pop   (queue_pop),
        .pc          (pc),
        .op          (op),
        .op_valid    (op_valid),
        .op_ready    (op_ready)
    );

    mov_execute u_execute (
        .clk          (clk),
        .reset        (reset),
        .op           (op),
        .op_valid     (op_valid),
        .op_ready     (op_ready),
        .gpr_rd_id    (gpr_rd_id),
        .sreg_rd_id   (sreg_rd_id),
        .rd_word      (rd_word),
        .gpr_rd_data  (gpr_rd_data),
        .sreg_rd_data (sreg_rd_data),
        .base_id      (base_id),
        .index_id     (index_id),
        .base_data    (base_data),
        .index_data   (index_data),
        .ea_seg_id    (ea_seg_id),
        .ea_seg_data  (ea_seg_data),
        .wb_req       (wb_req),
        .wb_rsp       (wb_rsp),
        .result       (result)
    );

    register_writeback u_writeback (
        .clk          (clk),
        .reset        (reset),
        .result       (result),
        .gpr_rd_id    (gpr_rd_id),
        .sreg_rd_id   (sreg_rd_id),
        .rd_word      (rd_word),
        .gpr_rd_data  (gpr_rd_data),
        .sreg_rd_data (sreg_rd_data),
        .base_id      (base_id),
        .index_id     (index_id),
        .base_data    (base_data),
        .index_data   (index_data),
        .ea_seg_id    (ea_seg_id),
        .ea_seg_data  (ea_seg_data)
    );

endmodule

`default_nettype wire

//--- dv/tb_execution_unit.sv
`default_nettype none

module tb_execution_unit
    import eu_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // section offsets inside the stimulus image
    localparam int QUEUE_BASE = 'h08;
    localparam int LOAD_BASE  = 'hA0 - 'h20;
    localparam int WRITE_BASE = 'hA0;

    logic clk;
    logic reset;
    byte_t queue_data;
    logic queue_empty;
    logic queue_pop;
    word_t pc;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;

    // address(5) data(4) sel(1) hex digits per bus entry
    logic [39:0] stim [0:255];
    logic [39:0] expected;
    int n_bytes;
    int n_loads;
    int n_writes;
    int q_idx;
    int loads_seen;
    int writes_seen;
    int cycle_count;
    int limit;
    int value_errors;
    int protocol_errors;
    logic pop_seen;
    logic finished;
    logic busy;
    logic [1:0] wait_left;
    logic [15:0] lfsr;
    wb_req_t held_req;

    execution_unit DUT (
        .clk         (clk),
        .reset       (reset),
        .queue_data  (queue_data),
        .queue_empty (queue_empty),
        .queue_pop   (queue_pop),
        .pc          (pc),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp)
    );

    always #2 clk = ~clk;

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one step per random bit
    function automatic logic take_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr_next(lfsr);
        return b;
    endfunction

    // present the next byte, with a random one-cycle gap
    task automatic drive_queue();
        if (pop_seen)
            q_idx++;
        if (q_idx < n_bytes)
        begin
            queue_data  = stim[QUEUE_BASE + q_idx][7:0];
            queue_empty = take_bit();
        end
        else
            queue_empty = 1'b1;
    endtask

    task automatic check_write();
        expected = stim[WRITE_BASE + writes_seen];
        assert (writes_seen < n_writes && wb_req.adr == expected[39:20] &&
                wb_req.dat_o == expected[19:4] && wb_req.sel == expected[1:0])
        else
        begin
            value_errors++;
            $display("ERR %0t: write %0d adr %h dat %h sel %b, expected %h", $time,
                     writes_seen, wb_req.adr, wb_req.dat_o, wb_req.sel, expected);
        end
        writes_seen++;
    endtask

    // read data goes back on the bus with the ack
    task automatic check_read();
        expected = stim[LOAD_BASE + loads_seen];
        assert (loads_seen < n_loads && wb_req.adr == expected[39:20] &&
                wb_req.sel == expected[1:0])
        else
        begin
            value_errors++;
            $display("ERR %0t: read %0d adr %h sel %b, expected %h", $time,
                     loads_seen, wb_req.adr, wb_req.sel, expected);
        end
        wb_rsp.dat_i = expected[19:4];
        loads_seen++;
    endtask

    // memory model, 0 to 3 wait states per access
    task automatic drive_bus();
        if (wb_rsp.ack)
        begin
            wb_rsp.ack = 1'b0;
            busy       = 1'b0;
        end
        else if (wb_req.cyc && wb_req.stb)
        begin
            if (!busy)
            begin
                busy         = 1'b1;
                held_req     = wb_req;
                wait_left[1] = take_bit();
                wait_left[0] = take_bit();
                if (wb_req.we)
                    check_write();
                else
                    check_read();
            end
            assert (wb_req === held_req)
            else
            begin
                protocol_errors++;
                $display("ERR %0t: request changed before ack, adr %h", $time, wb_req.adr);
            end
            if (wait_left == 2'd0)
                wb_rsp.ack = 1'b1;
            else
                wait_left--;
        end
    endtask

    initial
    begin
        clk             = 1'b0;
        reset           = 1'b1;
        queue_data      = '0;
        queue_empty     = 1'b1;
        wb_rsp          = '0;
        lfsr            = 16'd3;
        q_idx           = 0;
        loads_seen      = 0;
        writes_seen     = 0;
        cycle_count     = 0;
        value_errors    = 0;
        protocol_errors = 0;
        pop_seen        = 1'b0;
        finished        = 1'b0;
        busy            = 1'b0;
        wait_left       = '0;
        held_req        = '0;
        $readmemh("dv/eu_stim.txt", stim);
        assert (!$isunknown(stim[0]) && stim[0] != '0)
        else
        begin
            protocol_errors++;
            $display("stimulus file dv/eu_stim.txt is missing or empty");
        end
        n_bytes  = int'(stim[0][31:0]);
        n_loads  = int'(stim[1][31:0]);
        n_writes = int'(stim[2][31:0]);
        // bytes may stall, bus accesses add wait states
        limit = 20 * n_bytes + 10 * (n_loads + n_writes);
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        while (!finished && cycle_count < limit)
        begin
            drive_queue();
            drive_bus();
            // mid-cycle sample, inputs have settled
            @(negedge clk);
            assert (!(queue_pop && queue_empty))
            else
            begin
                protocol_errors++;
                $display("ERR %0t: queue_pop high while queue_empty is high", $time);
            end
            pop_seen = queue_pop;
            finished = (q_idx >= n_bytes) && (writes_seen == n_writes) &&
                       (loads_seen == n_loads) && !busy;
            cycle_count++;
            @(posedge clk);
            #1;
        end
        if (!finished)
        begin
            protocol_errors++;
            $display("timeout after %0d cycles, the DUT stopped making progress (%0d of %0d bytes)",
                     cycle_count, q_idx, n_bytes);
        end
        assert (pc == word_t'(n_bytes))
        else
        begin
            value_errors++;
            $display("ERR %0t: pc %h after the stream, expected %h", $time, pc, n_bytes);
        end
        assert (writes_seen == n_writes && loads_seen == n_loads)
        else
        begin
            value_errors++;
            $display("ERR %0t: %0d writes and %0d reads, expected %0d and %0d", $time,
                     writes_seen, loads_seen, n_writes, n_loads);
        end
        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/eu_stim.txt
// @00 counts in hex: queue bytes, reads, writes. @08 queue bytes, one instruction group per line
// @80 reads and @A0 writes in bus order, hex address(5) data(4) sel(1)
@00 6A 3 12
@08 B8 34 12                              // MOV AW,1234h
89 06 00 01                               // MOV [0100h],AW
B4 56 B0 78                               // MOV AH,56h  MOV AL,78h
89 06 02 01                               // MOV [0102h],AW
88 26 04 01                               // MOV [0104h],AH byte store
8B 0E 00 02 89 0E 02 02                   // load CW, store CW
8A 16 04 02 89 16 06 02                   // byte load DL, store DW
BB 00 10 BD 00 20 BE 30 00 BF 04 00       // BW=1000 BP=2000 IX=0030 IY=0004
B9 F0 FF 8E D9 BA 00 01 8E D2             // DS0=FFF0 SS=0100 through CW and DW
8C 1E 10 00                               // MOV [0010h],DS0
89 40 F0 89 41 F0 89 42 F0 89 43 F0       // AW through rm 000-011, disp -16
89 44 F0 89 45 F0 89 46 F0 89 47 F0       // AW through rm 100-111, disp -16
C7 80 00 01 BC 9A C6 04 5A                // MOV [BW+IX+0100h],9ABCh  MOV byte [IX],5Ah
8B 0B 89 0E 20 00 89 CC 89 26 22 00       // load CW from [BP+IY], store CW, SP=CW, store SP
// reads, data column is what the memory returns
@80 00200ABCD3 0020499EF1 0300443213
// writes
@A0 0010012343 0010256783 0010400561
00202ABCD3 0020600EF3 FFF10FFF03
00F2056783 00EF456783 0302056783
02FF456783 FFF2056783 0FEF456783
02FF056783 00EF056783 010309ABC3
FFF30005A1 FFF2043213 FFF2243213

//--- files.f
+incdir+source
source/eu_pkg.sv
source/instruction_decoder.sv
source/mov_execute.sv
source/register_writeback.sv
source/execution_unit.sv
dv/tb_execution_unit.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator and run from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module tb_execution_unit \
    -f files.f -o tb_execution_unit > build.log 2>&1 &&
./obj_dir/tb_execution_unit > sim.log 2>&1 ||
{ cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0
